/* fm_mixer.f */
hdl/fm_mixer_cfg_pkg.sv
hdl/fm_patch_pkg.sv
hdl/slot_sequencer.sv
hdl/patch_regs.sv
hdl/mod_matrix.sv
hdl/vol_mixer.sv
hdl/fm_mixer.sv
test/fm_mixer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fm_mixer_tb
FILELIST  ?= fm_mixer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/fm_mixer_tb.sv */
`timescale 1ns/100ps

module fm_mixer_tb
    import fm_mixer_cfg_pkg::*;
    import fm_patch_pkg::*;
();

    typedef struct {
        string  name;
        patch_t setup;
        int     frames;
        int     seed;          // offset on the base seed
        bit     extreme;       // full-scale samples and envelopes
        int     restart_at;    // length of the second frame, 0 for a full one
    } test_t;

    typedef struct {
        mod_t   m;
        bit     pulse;
        audio_t l;
        audio_t r;
    } expect_t;

    logic      sCLK_XVXENVS;
    logic      rst_n;
    logic      slot_zero;
    env_t      env_level;
    sample_t   osc_sample;
    adr_t      adr;
    reg_data_t wr_data;
    logic      write;
    logic      read;
    reg_data_t rd_data;
    mod_t      modulation;
    audio_t    lsound_out;
    audio_t    rsound_out;
    logic      sound_valid;

    test_t       tests[$];
    bit          table_ready;
    logic [31:0] rng;
    int          mod_errs;
    int          audio_errs;
    int          reg_errs;
    int          pulse_errs;

    // reference model state
    sample_t mem_m [VOICES][V_OSC];
    longint  lacc_m;
    longint  racc_m;
    bit      started_m;
    bit      frame_seen_m;
    int      cnt_m;
    expect_t stage1;    // slot driven one cycle ago
    expect_t stage2;    // slot driven two cycles ago

    fm_mixer dut_i (.*);

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #10 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic longint clip(input longint v, input longint lo, input longint hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    function automatic patch_t make_patch(input logic [127:0] mat, input logic [31:0] lvl,
                                          input logic [31:0] pan, input coef_t master);
        patch_t p;
        p.mat    = mat;
        p.level  = lvl;
        p.pan    = pan;
        p.master = master;
        return p;
    endfunction

    function automatic reg_data_t fill_byte(input adr_t a);
        return reg_data_t'(a * 8'd29 + 8'h3b);    // odd multiplier, distinct per address
    endfunction

    function automatic bit is_mapped(input adr_t a);
        return (a <= ADR_MASTER) || (a >= ADR_NAME && int'(a) < int'(ADR_NAME) + 16);
    endfunction

    task automatic add_test(input string name, input patch_t p, input int frames,
                            input int seed, input bit extreme, input int restart_at);
        test_t t;
        t.name       = name;
        t.setup      = p;
        t.frames     = frames;
        t.seed       = seed;
        t.extreme    = extreme;
        t.restart_at = restart_at;
        tests.push_back(t);
    endtask

    task automatic check_mod(input string name, input mod_t exp_v, input mod_t act_v);
        if (act_v !== exp_v) begin
            mod_errs++;
            $display("MISMATCH %s modulation expected %0d actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic check_audio(input string name, input audio_t exp_v, input audio_t act_v);
        if (act_v !== exp_v) begin
            audio_errs++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t exp_v, input reg_data_t act_v);
        if (act_v !== exp_v) begin
            reg_errs++;
            $display("MISMATCH %s expected %02h actual %02h", name, exp_v, act_v);
        end
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        slot_zero = 1'b0;
        write     = 1'b0;
        read      = 1'b0;
        repeat (10) @(posedge sCLK_XVXENVS);
        @(negedge sCLK_XVXENVS);
        rst_n = 1'b1;
        for (int v = 0; v < VOICES; v++) begin
            for (int o = 0; o < V_OSC; o++) mem_m[v][o] = '0;
        end
        lacc_m       = 0;
        racc_m       = 0;
        started_m    = 1'b0;
        frame_seen_m = 1'b0;
        cnt_m        = 0;
        stage1       = '{m: '0, pulse: 1'b0, l: '0, r: '0};
        stage2       = stage1;
    endtask

    task automatic bus_write(input adr_t a, input reg_data_t d);
        adr     = a;
        wr_data = d;
        write   = 1'b1;
        @(negedge sCLK_XVXENVS);
        write = 1'b0;
    endtask

    task automatic bus_read(input adr_t a, output reg_data_t d);
        adr  = a;
        read = 1'b1;
        @(negedge sCLK_XVXENVS);
        read = 1'b0;
        d    = rd_data;    // registered one cycle after the strobe
    endtask

    task automatic run_reg_test();
        reg_data_t d;
        check_reg("regs_rd_data_reset", 8'd0, rd_data);
        for (int i = 0; i < 128; i++) begin
            bus_read(adr_t'(i), d);
            check_reg($sformatf("regs_reset@%02h", i), (i == ADR_MASTER) ? 8'd127 : 8'd0, d);
        end
        for (int i = 0; i < 128; i++) bus_write(adr_t'(i), fill_byte(adr_t'(i)));
        for (int i = 0; i < 128; i++) begin
            bus_read(adr_t'(i), d);
            check_reg($sformatf("regs_rw@%02h", i),
                      is_mapped(adr_t'(i)) ? fill_byte(adr_t'(i)) : 8'd0, d);
        end
    endtask

    // check the slot two cycles back, then drive one new slot and predict it
    task automatic drive_slot(input test_t t, input bit z);
        sample_t s;
        env_t    e;
        int      idx;
        int      v;
        int      o;
        longint  sum;
        longint  c;
        longint  lp;
        longint  rp;
        expect_t nx;
        check_mod(t.name, stage2.m, modulation);
        if (sound_valid !== stage2.pulse) begin
            pulse_errs++;
            if (stage2.pulse) $display("%s: sound_valid pulse is missing", t.name);
            else $display("%s: sound_valid pulsed where no frame ended", t.name);
        end else if (stage2.pulse) begin
            check_audio({t.name, " left"}, stage2.l, lsound_out);
            check_audio({t.name, " right"}, stage2.r, rsound_out);
        end
        stage2 = stage1;
        rng = lcg_next(rng);
        s   = t.extreme ? (rng[31] ? 17'sh0ffff : 17'sh10000) : rng[31:15];
        rng = lcg_next(rng);
        e   = t.extreme ? (rng[31] ? 8'sh7f : 8'sh80) : rng[31:24];
        slot_zero  = z;
        env_level  = e;
        osc_sample = s;
        started_m = started_m | z;
        idx   = (z || cnt_m == SLOTS - 1) ? 0 : cnt_m + 1;
        cnt_m = idx;
        v     = idx / V_OSC;
        o     = idx % V_OSC;
        nx    = '{m: '0, pulse: 1'b0, l: '0, r: '0};
        if (started_m) begin
            sum = 0;
            for (int k = 0; k < V_OSC; k++) begin
                sum += longint'(t.setup.mat[k * V_OSC + o]) * longint'(mem_m[v][k]);
            end
            nx.m        = mod_t'(clip(sum >>> MOD_SHIFT, -1024, 1023));
            mem_m[v][o] = s;    // after the read, as in the hardware
            c  = (((longint'(s) * longint'(e)) >>> 7) * longint'(t.setup.level[o])) >>> 7;
            lp = (c * (255 - int'(t.setup.pan[o]))) >>> 8;
            rp = (c * int'(t.setup.pan[o])) >>> 8;
            if (z) begin
                if (frame_seen_m) begin
                    nx.pulse = 1'b1;
                    nx.l = audio_t'(clip((lacc_m * t.setup.master) >>> MIX_SHIFT, -32768, 32767));
                    nx.r = audio_t'(clip((racc_m * t.setup.master) >>> MIX_SHIFT, -32768, 32767));
                end
                frame_seen_m = 1'b1;
                lacc_m       = lp;
                racc_m       = rp;
            end else begin
                lacc_m += lp;
                racc_m += rp;
            end
        end
        stage1 = nx;
        @(negedge sCLK_XVXENVS);
    endtask

    task automatic run_stream(input test_t t);
        int len;
        apply_reset();
        check_audio({t.name, " reset left"}, '0, lsound_out);
        check_audio({t.name, " reset right"}, '0, rsound_out);
        for (int i = 0; i < SLOTS; i++) bus_write(adr_t'(int'(ADR_MAT) + i), t.setup.mat[i]);
        for (int i = 0; i < V_OSC; i++) begin
            bus_write(adr_t'(int'(ADR_LEVEL) + i), t.setup.level[i]);
            bus_write(adr_t'(int'(ADR_PAN) + i), t.setup.pan[i]);
        end
        bus_write(ADR_MASTER, t.setup.master);
        rng = 32'hf60c + t.seed;
        repeat (3) drive_slot(t, 1'b0);    // before any slot_zero
        for (int f = 0; f < t.frames; f++) begin
            len = (f == 1 && t.restart_at != 0) ? t.restart_at : SLOTS;
            for (int k = 0; k < len; k++) drive_slot(t, k == 0);
        end
        drive_slot(t, 1'b1);    // closes the last frame
        repeat (2) drive_slot(t, 1'b0);
    endtask

    initial begin
        rst_n      = 1'b0;
        slot_zero  = 1'b0;
        env_level  = '0;
        osc_sample = '0;
        adr        = '0;
        wr_data    = '0;
        write      = 1'b0;
        read       = 1'b0;
        add_test("zero_matrix", make_patch('0, 32'h40404040, 32'h80808080, 8'h7f), 3, 0, 0, 0);
        add_test("diag_single", make_patch(128'h00000000_00400000_00000000_00000000,
                 32'h7f7f7f7f, 32'h80808080, 8'h7f), 3, 1, 0, 0);
        add_test("random_matrix", make_patch(128'h7f813ac5_e21960a4_d37e0b9c_45f28e17,
                 32'h7f604020, 32'h10a0ff00, 8'h50), 4, 2, 0, 0);
        add_test("mod_saturation", make_patch(128'h7f7f7f7f_80808080_7f7f7f7f_80808080,
                 32'h7f7f7f7f, 32'h80808080, 8'h7f), 4, 3, 1, 0);
        add_test("pan_left", make_patch('0, 32'h7f7f7f7f, 32'h00000000, 8'h7f), 3, 4, 0, 0);
        add_test("pan_right", make_patch('0, 32'h7f7f7f7f, 32'hffffffff, 8'h7f), 3, 5, 0, 0);
        add_test("pan_mixed", make_patch(128'h05f3c2a1_7e10b4d9_3366e08f_9a1c47bb,
                 32'h6a30557f, 32'h2060c0f0, 8'h30), 5, 6, 0, 0);
        add_test("master_neg_sat", make_patch('0, 32'h7f7f7f7f, 32'h40c040c0, 8'h90),
                 4, 7, 1, 0);
        add_test("mid_restart", make_patch(128'h1c9f4077_0ad2e5b3_6e08c1f4_3b27a995,
                 32'h5070407f, 32'h3080d0ff, 8'h60), 4, 8, 0, 7);
        table_ready = 1'b1;
        apply_reset();
        run_reg_test();
        foreach (tests[i]) run_stream(tests[i]);
        $display("errors: modulation %0d, audio %0d, register %0d, pulse %0d",
                 mod_errs, audio_errs, reg_errs, pulse_errs);
        if (mod_errs + audio_errs + reg_errs + pulse_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // stream length plus register test, resets and patch loads
    initial begin
        longint cycles;
        wait (table_ready);
        cycles = 4 * 128 + 500;
        foreach (tests[i]) cycles += (tests[i].frames + 1) * SLOTS + 60;
        #(cycles * 20);
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display("errors: modulation %0d, audio %0d, register %0d, pulse %0d",
                 mod_errs, audio_errs, reg_errs, pulse_errs);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* hdl/fm_mixer.sv */
`timescale 1ns/100ps

module fm_mixer
    import fm_mixer_cfg_pkg::*;
    import fm_patch_pkg::*;
(
    input  logic      sCLK_XVXENVS,
    input  logic      rst_n,
    // slot stream from the oscillator side
    input  logic      slot_zero,
    input  env_t      env_level,
    input  sample_t   osc_sample,
    // patch bus
    input  adr_t      adr,
    input  reg_data_t wr_data,
    input  logic      write,
    input  logic      read,
    output reg_data_t rd_data,
    // results
    output mod_t      modulation,     // back to the oscillator
    output audio_t    lsound_out,
    output audio_t    rsound_out,
    output logic      sound_valid
);

    slot_t  cur_slot;   // shared by both paths
    patch_t patch;

    slot_sequencer seq_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .slot_zero    (slot_zero),
        .env_level    (env_level),
        .osc_sample   (osc_sample),
        .cur_slot     (cur_slot)
    );

    patch_regs regs_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .adr          (adr),
        .wr_data      (wr_data),
        .write        (write),
        .read         (read),
        .rd_data      (rd_data),
        .patch        (patch)
    );

    mod_matrix matrix_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .cur_slot     (cur_slot),
        .patch        (patch),
        .modulation   (modulation)
    );

    vol_mixer mixer_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .cur_slot     (cur_slot),
        .patch        (patch),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sound_valid  (sound_valid)
    );

endmodule

/* hdl/vol_mixer.sv */
`timescale 1ns/100ps

module vol_mixer
    import fm_mixer_cfg_pkg::*;
    import fm_patch_pkg::*;
(
    input  logic   sCLK_XVXENVS,
    input  logic   rst_n,
    input  slot_t  cur_slot,
    input  patch_t patch,
    output audio_t lsound_out,
    output audio_t rsound_out,
    output logic   sound_valid    // one-cycle pulse per frame
);

    coef_t lvl;
    pan_t  pan;

    logic signed [$bits(sample_t)+$bits(env_t)-1:0]              env_prod;
    logic signed [$bits(env_prod)-SCALE_SHIFT+$bits(coef_t)-1:0] lvl_prod;

    acc_t contrib;           // scaled slot, before pan
    acc_t l_part;
    acc_t r_part;
    acc_t lacc;
    acc_t racc;
    logic frame_seen;        // a frame has been under accumulation

    // contribution times an unsigned pan weight
    function automatic acc_t pan_part(input acc_t c, input pan_t w);
        logic signed [ACC_W+$bits(pan_t):0] prod;
        prod = c * $signed({1'b0, w});
        return prod[ACC_W+PAN_SHIFT-1:PAN_SHIFT];
    endfunction

    // master volume then clip to the audio width
    function automatic audio_t master_out(input acc_t acc, input coef_t vol);
        logic signed [ACC_W+$bits(coef_t)-1:0]           prod;
        logic signed [ACC_W+$bits(coef_t)-MIX_SHIFT-1:0] scl;
        prod = acc * vol;
        scl  = prod[$bits(prod)-1:MIX_SHIFT];
        if (&scl[$bits(scl)-1:AUDIO_W-1] || ~|scl[$bits(scl)-1:AUDIO_W-1]) begin
            return scl[AUDIO_W-1:0];
        end
        return scl[$bits(scl)-1] ? {1'b1, {(AUDIO_W-1){1'b0}}} : {1'b0, {(AUDIO_W-1){1'b1}}};
    endfunction

    assign lvl = patch.level[cur_slot.osc];
    assign pan = patch.pan[cur_slot.osc];

    assign env_prod = cur_slot.sample * cur_slot.env;
    assign lvl_prod = $signed(env_prod[$bits(env_prod)-1:SCALE_SHIFT]) * lvl;
    assign contrib  = acc_t'($signed(lvl_prod[$bits(lvl_prod)-1:SCALE_SHIFT]));

    assign l_part = pan_part(contrib, ~pan);    // 255 - pan
    assign r_part = pan_part(contrib, pan);

    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            lacc        <= '0;
            racc        <= '0;
            frame_seen  <= 1'b0;
            lsound_out  <= '0;
            rsound_out  <= '0;
            sound_valid <= 1'b0;
        end else begin
            sound_valid <= 1'b0;
            if (cur_slot.valid && cur_slot.first) begin
                if (frame_seen) begin    // nothing to emit on the very first frame start
                    lsound_out  <= master_out(lacc, patch.master);
                    rsound_out  <= master_out(racc, patch.master);
                    sound_valid <= 1'b1;
                end
                frame_seen <= 1'b1;
                lacc       <= l_part;    // restart with this slot
                racc       <= r_part;
            end else if (cur_slot.valid) begin
                lacc <= lacc + l_part;
                racc <= racc + r_part;
            end
        end
    end

endmodule

/* hdl/mod_matrix.sv */
`timescale 1ns/100ps

module mod_matrix
    import fm_mixer_cfg_pkg::*;
    import fm_patch_pkg::*;
(
    input  logic   sCLK_XVXENVS,
    input  logic   rst_n,
    input  slot_t  cur_slot,
    input  patch_t patch,
    output mod_t   modulation
);

    // latest sample of every oscillator, one row per voice
    sample_t mem [VOICES][V_OSC];

    logic signed [$bits(coef_t)+$bits(sample_t)+$clog2(V_OSC)-1:0] mod_sum;
    logic signed [$bits(mod_sum)-MOD_SHIFT-1:0]                     mod_scl;
    mod_t                                                           mod_sat;

    // weighted sum over the sources of this voice into the slot's oscillator
    always_comb begin
        mod_sum = '0;
        for (int s = 0; s < V_OSC; s++) begin
            mod_sum = mod_sum
                + coef_t'(patch.mat[s * V_OSC + int'(cur_slot.osc)])
                * mem[cur_slot.voice][s];    // read before this slot's write
        end
    end

    assign mod_scl = mod_sum[$bits(mod_sum)-1:MOD_SHIFT];

    always_comb begin
        if (&mod_scl[$bits(mod_scl)-1:MOD_W-1] || ~|mod_scl[$bits(mod_scl)-1:MOD_W-1]) begin
            mod_sat = mod_scl[MOD_W-1:0];
        end else if (mod_scl[$bits(mod_scl)-1]) begin
            mod_sat = {1'b1, {(MOD_W-1){1'b0}}};    // clip negative
        end else begin
            mod_sat = {1'b0, {(MOD_W-1){1'b1}}};    // clip positive
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < VOICES; v++) begin
                for (int o = 0; o < V_OSC; o++) begin
                    mem[v][o] <= '0;
                end
            end
        end else if (cur_slot.valid) begin
            mem[cur_slot.voice][cur_slot.osc] <= cur_slot.sample;
        end
    end

    // two cycles after the slot's inputs
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            modulation <= '0;
        end else begin
            modulation <= cur_slot.valid ? mod_sat : '0;
        end
    end

endmodule

/* hdl/patch_regs.sv */
`timescale 1ns/100ps

module patch_regs
    import fm_mixer_cfg_pkg::*;
    import fm_patch_pkg::*;
(
    input  logic      sCLK_XVXENVS,
    input  logic      rst_n,
    input  adr_t      adr,
    input  reg_data_t wr_data,
    input  logic      write,      // one-cycle strobe
    input  logic      read,       // one-cycle strobe
    output reg_data_t rd_data,
    output patch_t    patch
);

    reg_data_t name [NAME_LEN];   // storage only, not used by the datapath
    reg_data_t rd_mux;

    function automatic logic in_range(input adr_t a, input adr_t base, input int n);
        return (a >= base) && (int'(a) < int'(base) + n);
    endfunction

    // bases are aligned, so the low address bits are the entry index
    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            patch        <= '0;
            patch.master <= MASTER_INIT;
            for (int i = 0; i < NAME_LEN; i++) begin
                name[i] <= '0;
            end
        end else if (write) begin
            if (in_range(adr, ADR_MAT, SLOTS)) begin
                patch.mat[adr[$clog2(SLOTS)-1:0]] <= wr_data;
            end
            if (in_range(adr, ADR_LEVEL, V_OSC)) begin
                patch.level[adr[$clog2(V_OSC)-1:0]] <= wr_data;
            end
            if (in_range(adr, ADR_PAN, V_OSC)) begin
                patch.pan[adr[$clog2(V_OSC)-1:0]] <= wr_data;
            end
            if (adr == ADR_MASTER) begin
                patch.master <= wr_data;
            end
            if (in_range(adr, ADR_NAME, NAME_LEN)) begin
                name[adr[$clog2(NAME_LEN)-1:0]] <= wr_data;
            end
        end
    end

    always_comb begin
        rd_mux = '0;    // unmapped reads
        if (in_range(adr, ADR_MAT, SLOTS)) begin
            rd_mux = patch.mat[adr[$clog2(SLOTS)-1:0]];
        end else if (in_range(adr, ADR_LEVEL, V_OSC)) begin
            rd_mux = patch.level[adr[$clog2(V_OSC)-1:0]];
        end else if (in_range(adr, ADR_PAN, V_OSC)) begin
            rd_mux = patch.pan[adr[$clog2(V_OSC)-1:0]];
        end else if (adr == ADR_MASTER) begin
            rd_mux = patch.master;
        end else if (in_range(adr, ADR_NAME, NAME_LEN)) begin
            rd_mux = name[adr[$clog2(NAME_LEN)-1:0]];
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read) begin
            rd_data <= rd_mux;    // held until the next read
        end
    end

endmodule

/* hdl/slot_sequencer.sv */
`timescale 1ns/100ps

module slot_sequencer
    import fm_mixer_cfg_pkg::*;
(
    input  logic    sCLK_XVXENVS,
    input  logic    rst_n,
    input  logic    slot_zero,     // first slot of a frame is on the inputs now
    input  env_t    env_level,
    input  sample_t osc_sample,
    output slot_t   cur_slot
);

    slot_idx_t cnt;        // index of the slot registered last cycle
    slot_idx_t idx;        // index of the slot on the inputs
    logic      started;

    always_comb begin
        if (slot_zero) begin
            idx = '0;
        end else if (cnt == slot_idx_t'(SLOTS - 1)) begin
            idx = '0;    // wrap
        end else begin
            idx = cnt + 1'b1;
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            started  <= 1'b0;
            cur_slot <= '0;
        end else begin
            cnt     <= idx;
            started <= started | slot_zero;

            cur_slot.valid  <= started | slot_zero;
            cur_slot.first  <= slot_zero;
            cur_slot.voice  <= idx[$bits(slot_idx_t)-1:$bits(osc_t)];
            cur_slot.osc    <= idx[$bits(osc_t)-1:0];
            cur_slot.env    <= env_level;
            cur_slot.sample <= osc_sample;
        end
    end

endmodule

/* hdl/fm_patch_pkg.sv */
package fm_patch_pkg;

    import fm_mixer_cfg_pkg::*;

    typedef logic signed [7:0] coef_t;    // matrix coefficient, level, master
    typedef logic [7:0]        pan_t;     // 0 full left, 255 full right
    typedef logic [6:0]        adr_t;
    typedef logic [7:0]        reg_data_t;

    localparam int NAME_LEN = 16;         // patch name bytes

    // register map
    localparam adr_t ADR_MAT    = 7'h00;  // SLOTS entries, source * V_OSC + dest
    localparam adr_t ADR_LEVEL  = 7'h10;  // V_OSC entries
    localparam adr_t ADR_PAN    = 7'h14;  // V_OSC entries
    localparam adr_t ADR_MASTER = 7'h18;
    localparam adr_t ADR_NAME   = 7'h20;  // NAME_LEN bytes

    localparam coef_t MASTER_INIT = 8'sd127;

    localparam int MOD_SHIFT   = 13;      // matrix sum down to modulation range
    localparam int MIX_SHIFT   = 7;       // master volume stage
    localparam int SCALE_SHIFT = 7;       // after envelope and after level
    localparam int PAN_SHIFT   = 8;       // after pan weight

    typedef struct packed {
        coef_t [SLOTS-1:0] mat;
        coef_t [V_OSC-1:0] level;
        pan_t  [V_OSC-1:0] pan;
        coef_t             master;
    } patch_t;

endpackage

/* hdl/fm_mixer_cfg_pkg.sv */
package fm_mixer_cfg_pkg;

    localparam int VOICES  = 4;                // voices in the engine
    localparam int V_OSC   = 4;                // oscillators per voice
    localparam int SLOTS   = VOICES * V_OSC;   // slots per frame

    localparam int AUDIO_W = 16;               // output audio width
    localparam int MOD_W   = 11;               // modulation word back to the oscillator
    localparam int ACC_W   = 24;               // frame accumulator, with headroom for 16 slots

    typedef logic [$clog2(VOICES)-1:0] voice_t;
    typedef logic [$clog2(V_OSC)-1:0]  osc_t;
    typedef logic [$clog2(SLOTS)-1:0]  slot_idx_t;   // voice in the high bits, osc in the low

    typedef logic signed [7:0]  env_t;       // envelope level times velocity
    typedef logic signed [16:0] sample_t;    // sine table output

    typedef logic signed [MOD_W-1:0]   mod_t;
    typedef logic signed [AUDIO_W-1:0] audio_t;
    typedef logic signed [ACC_W-1:0]   acc_t;

    // one oscillator slot as seen by both paths
    typedef struct packed {
        logic    valid;    // seen a slot_zero since reset
        logic    first;    // first slot of a frame
        voice_t  voice;
        osc_t    osc;
        env_t    env;
        sample_t sample;
    } slot_t;

endpackage
